// File: Makefile
# Verilator build and run of the scalar unit testbench.
# Any variable can be overridden on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= scalar_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# The log decides pass or fail, not the exit status of the binary
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src.f
+incdir+verilog
verilog/scalar_pkg.sv
verilog/issue_stage.sv
verilog/index_unit.sv
verilog/reg_file.sv
verilog/operand_read.sv
verilog/scalar_alu.sv
verilog/scalar_unit_top.sv
verif/scalar_unit_tb.sv

// File: verif/scalar_unit_tb.sv
// Testbench for the scalar back-end pipeline.
// Applies a command table twice, first with result_ready held high and
// then with a random result_ready, and checks every result against a
// register-window reference model kept in the testbench.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module scalar_unit_tb;

	localparam int NUM_ROWS       = 24;
	localparam int RESET_CYCLES   = 10;
	// Two passes over the table
	localparam int TIMEOUT_CYCLES = 8 * 2 * NUM_ROWS + RESET_CYCLES;

	typedef struct packed {
		scalar_pkg::opcode_e                         op;
		logic [`THREAD_W-1:0]                        thread;
		logic [`WIN_IDX_W-1:0]                       dst;
		scalar_pkg::src_operand_t [`NUM_SRC-1:0]     src;
	} row_t;

	logic                      clock = 1'b0;
	logic                      reset;
	logic                      command_valid;
	logic                      command_ready;
	scalar_pkg::opcode_e       command_op;
	logic [`WIN_IDX_W-1:0]     command_dst;
	scalar_pkg::src_operand_t  command_src [`NUM_SRC];
	logic [`THREAD_W-1:0]      command_thread;
	logic                      result_valid;
	logic                      result_ready;
	scalar_pkg::reg_idx_t      result_index;
	scalar_pkg::data_t         result_data;

	row_t                  rows [NUM_ROWS];
	int                    row_count;
	scalar_pkg::data_t     model_regs [`NUM_REGS];
	scalar_pkg::reg_idx_t  exp_index [$];
	scalar_pkg::data_t     exp_data [$];
	int                    exp_cycle [$];
	int                    cycle;
	bit                    accepted;
	bit                    random_ready;
	bit                    holding;
	scalar_pkg::reg_idx_t  held_index;
	scalar_pkg::data_t     held_data;
	logic [31:0]           rng_state;

	scalar_unit_top u_dut (
		.clock          (clock),
		.reset          (reset),
		.command_valid  (command_valid),
		.command_ready  (command_ready),
		.command_op     (command_op),
		.command_dst    (command_dst),
		.command_src    (command_src),
		.command_thread (command_thread),
		.result_valid   (result_valid),
		.result_ready   (result_ready),
		.result_index   (result_index),
		.result_data    (result_data)
	);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// Error reporting and compare tasks
	//////////////////////////////////////////////////

	task automatic report_error(input string line);
		$display("%s", line);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_index(input scalar_pkg::reg_idx_t actual,
			input scalar_pkg::reg_idx_t expected, input string what);
		if (actual !== expected) begin
			report_error($sformatf("FAILED at %0t ns: %s, got %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_data(input scalar_pkg::data_t actual,
			input scalar_pkg::data_t expected, input string what);
		if (actual !== expected) begin
			report_error($sformatf("FAILED at %0t ns: %s, got 0x%08h, expected 0x%08h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			report_error($sformatf("FAILED at %0t ns: %s, got %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_latency(input int actual, input int expected);
		if (actual != expected) begin
			report_error($sformatf("FAILED at %0t ns: result latency %0d cycles, expected %0d",
				$time, actual, expected));
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic scalar_pkg::reg_idx_t window_index(input logic [`THREAD_W-1:0] thread,
			input logic [`WIN_IDX_W-1:0] idx);
		return scalar_pkg::reg_idx_t'(int'(thread) * `WIN_REGS + int'(idx));
	endfunction

	function automatic scalar_pkg::data_t operand_value(input scalar_pkg::src_operand_t s,
			input logic [`THREAD_W-1:0] thread);
		int constant;
		if (s.is_imm) begin
			constant = $signed(s.field.imm);
			return scalar_pkg::data_t'(constant);
		end
		return model_regs[window_index(thread, s.field.regs.idx)];
	endfunction

	// Runs on every accepted command, in acceptance order
	task automatic apply_model();
		scalar_pkg::data_t     a;
		scalar_pkg::data_t     b;
		scalar_pkg::data_t     c;
		scalar_pkg::data_t     value;
		scalar_pkg::reg_idx_t  dst;
		a = operand_value(command_src[0], command_thread);
		b = operand_value(command_src[1], command_thread);
		c = operand_value(command_src[2], command_thread);
		case (command_op)
			scalar_pkg::OP_ADD: value = a + b + c;
			scalar_pkg::OP_SUB: value = a - b;
			scalar_pkg::OP_AND: value = a & b;
			scalar_pkg::OP_MAC: value = a * b + c;
		endcase
		dst = window_index(command_thread, command_dst);
		model_regs[dst] = value;
		exp_index.push_back(dst);
		exp_data.push_back(value);
		exp_cycle.push_back(cycle);
	endtask

	//////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////

	function automatic scalar_pkg::src_operand_t reg_src(input int idx);
		scalar_pkg::src_operand_t s;
		s = '0;
		s.field.regs.idx = `WIN_IDX_W'(idx);
		return s;
	endfunction

	function automatic scalar_pkg::src_operand_t imm_src(input int value);
		scalar_pkg::src_operand_t s;
		s.is_imm = 1'b1;
		s.field.imm = `IMM_W'(value);
		return s;
	endfunction

	task automatic add_row(input scalar_pkg::opcode_e op, input int thread, input int dst,
			input scalar_pkg::src_operand_t a, input scalar_pkg::src_operand_t b,
			input scalar_pkg::src_operand_t c);
		rows[row_count].op     = op;
		rows[row_count].thread = `THREAD_W'(thread);
		rows[row_count].dst    = `WIN_IDX_W'(dst);
		rows[row_count].src[0] = a;
		rows[row_count].src[1] = b;
		rows[row_count].src[2] = c;
		row_count++;
	endtask

	// No row reads the register written by the row just before it
	task automatic build_table();
		row_count = 0;
		// Reads before any write, then immediate loads of r2 in all four threads
		add_row(scalar_pkg::OP_ADD, 0, 1, reg_src(0), reg_src(2), reg_src(3));
		add_row(scalar_pkg::OP_ADD, 0, 2, imm_src(100), imm_src(-7), imm_src(5));
		add_row(scalar_pkg::OP_ADD, 1, 2, imm_src(-1), imm_src(-2048), imm_src(0));
		add_row(scalar_pkg::OP_ADD, 0, 3, imm_src(2047), imm_src(1), imm_src(0));
		add_row(scalar_pkg::OP_ADD, 1, 3, imm_src(300), imm_src(-50), imm_src(7));
		add_row(scalar_pkg::OP_ADD, 2, 2, imm_src(12), imm_src(0), imm_src(0));
		add_row(scalar_pkg::OP_ADD, 3, 2, imm_src(-9), imm_src(0), imm_src(0));
		// Register operations, some reading the write from two rows back
		add_row(scalar_pkg::OP_SUB, 0, 4, reg_src(2), reg_src(3), imm_src(0));
		add_row(scalar_pkg::OP_SUB, 1, 4, reg_src(3), reg_src(2), imm_src(0));
		add_row(scalar_pkg::OP_AND, 2, 5, reg_src(2), imm_src(15), imm_src(0));
		add_row(scalar_pkg::OP_AND, 1, 5, reg_src(2), reg_src(4), imm_src(0));
		add_row(scalar_pkg::OP_MAC, 0, 6, reg_src(2), reg_src(3), reg_src(4));
		add_row(scalar_pkg::OP_MAC, 3, 6, reg_src(2), reg_src(2), imm_src(3));
		add_row(scalar_pkg::OP_ADD, 0, 7, reg_src(6), reg_src(1), imm_src(1));
		add_row(scalar_pkg::OP_MAC, 1, 6, reg_src(5), imm_src(-3), reg_src(3));
		add_row(scalar_pkg::OP_SUB, 2, 6, reg_src(5), reg_src(2), imm_src(0));
		add_row(scalar_pkg::OP_AND, 3, 7, reg_src(6), imm_src(-1), imm_src(0));
		add_row(scalar_pkg::OP_ADD, 0, 0, reg_src(7), reg_src(4), reg_src(6));
		add_row(scalar_pkg::OP_SUB, 1, 0, reg_src(6), reg_src(5), imm_src(0));
		add_row(scalar_pkg::OP_MAC, 2, 7, reg_src(6), reg_src(6), reg_src(2));
		add_row(scalar_pkg::OP_ADD, 3, 0, reg_src(7), reg_src(2), reg_src(6));
		add_row(scalar_pkg::OP_SUB, 0, 1, reg_src(0), reg_src(1), imm_src(0));
		add_row(scalar_pkg::OP_AND, 1, 7, reg_src(0), reg_src(4), imm_src(0));
		add_row(scalar_pkg::OP_MAC, 2, 0, reg_src(7), imm_src(5), reg_src(7));
	endtask

	//////////////////////////////////////////////////
	// Driver, on the falling edge
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic set_ready();
		if (random_ready) begin
			rng_state = xorshift(rng_state);
			result_ready = rng_state[4];
		end else begin
			result_ready = 1'b1;
		end
	endtask

	task automatic drive_row(input int i);
		command_op     = rows[i].op;
		command_thread = rows[i].thread;
		command_dst    = rows[i].dst;
		for (int p = 0; p < `NUM_SRC; p++) begin
			command_src[p] = rows[i].src[p];
		end
	endtask

	// Starts and ends on a falling edge, drains all results before returning
	task automatic run_pass(input bit random_mode);
		int i;
		random_ready  = random_mode;
		i             = 0;
		drive_row(0);
		command_valid = 1'b1;
		set_ready();
		while (i < NUM_ROWS) begin
			@(negedge clock);
			if (accepted) begin
				i++;
				if (i < NUM_ROWS) begin
					drive_row(i);
				end else begin
					command_valid = 1'b0;
				end
			end
			set_ready();
		end
		while (exp_index.size() > 0) begin
			@(negedge clock);
			set_ready();
		end
	endtask

	//////////////////////////////////////////////////
	// Monitor, on the rising edge
	//////////////////////////////////////////////////

	always @(posedge clock) begin : monitor
		int latency;
		cycle++;
		if (cycle > TIMEOUT_CYCLES) begin
			report_error($sformatf("Timeout: the run did not finish within %0d cycles",
				TIMEOUT_CYCLES));
		end
		if (!reset) begin
			// A stalled result must stay put
			if (holding) begin
				check_flag(result_valid, 1'b1, "result_valid dropped while stalled");
				check_index(result_index, held_index, "result_index moved while stalled");
				check_data(result_data, held_data, "result_data moved while stalled");
			end
			if (result_valid && result_ready) begin
				if (exp_index.size() == 0) begin
					report_error("A result appeared with no command outstanding");
				end
				check_index(result_index, exp_index.pop_front(), "result_index");
				check_data(result_data, exp_data.pop_front(), "result_data");
				latency = cycle - exp_cycle.pop_front();
				if (!random_ready) begin
					check_latency(latency, 3);
				end
			end
			accepted = command_valid && command_ready;
			if (accepted) begin
				apply_model();
			end
			holding    = result_valid && !result_ready;
			held_index = result_index;
			held_data  = result_data;
		end
	end

	initial begin
		reset          = 1'b1;
		command_valid  = 1'b0;
		command_op     = scalar_pkg::OP_ADD;
		command_dst    = '0;
		command_thread = '0;
		for (int p = 0; p < `NUM_SRC; p++) begin
			command_src[p] = '0;
		end
		result_ready   = 1'b1;
		random_ready   = 1'b0;
		accepted       = 1'b0;
		holding        = 1'b0;
		cycle          = 0;
		rng_state      = 32'd17;
		for (int r = 0; r < `NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		build_table();
		if (row_count != NUM_ROWS) begin
			report_error("The command table length does not match NUM_ROWS");
		end

		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		check_flag(result_valid, 1'b0, "result_valid after reset");
		check_flag(command_ready, 1'b1, "command_ready after reset");

		run_pass(1'b0);
		run_pass(1'b1);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: verilog/index_unit.sv
// Operand index unit, one per source of a command.
// Maps a register source into the issuing thread's window or
// sign-extends an immediate, registered on the pipeline advance.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module index_unit (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      advance,
	input  scalar_pkg::src_operand_t  src,
	input  logic [`THREAD_W-1:0]      thread,
	output logic                      operand_is_imm,
	output scalar_pkg::reg_idx_t      operand_index,
	output scalar_pkg::data_t         operand_imm
);

	always_ff @(posedge clock) begin
		if (reset) begin
			operand_is_imm <= 1'b0;
			operand_index  <= '0;
		end else if (advance) begin
			operand_is_imm <= src.is_imm;
			// Immediates point at the window base, the index is then unused
			if (src.is_imm) begin
				operand_index <= {thread, {`WIN_IDX_W{1'b0}}};
			end else begin
				operand_index <= {thread, src.field.regs.idx};
			end
		end
	end

	// Constant view, sign-extended to a full word
	always_ff @(posedge clock) begin
		if (advance) begin
			operand_imm <= {{(`DATA_W-`IMM_W){src.field.imm[`IMM_W-1]}}, src.field.imm};
		end
	end

	// Index stays inside the window of the thread that issued it
	a_in_window: assert property (@(posedge clock) disable iff (reset)
		advance |=> (int'(operand_index) >= int'($past(thread)) * `WIN_REGS
			&& int'(operand_index) < (int'($past(thread)) + 1) * `WIN_REGS))
		else $error("operand index left the window of its thread");

endmodule

// File: verilog/issue_stage.sv
// Front of the scalar pipeline. Takes one command per cycle on a
// valid/ready handshake, forms the pipeline advance and registers
// op, valid and the window-mapped destination for stage one.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module issue_stage (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  command_valid,
	output logic                  command_ready,
	input  scalar_pkg::opcode_e   command_op,
	input  logic [`WIN_IDX_W-1:0] command_dst,
	input  logic [`THREAD_W-1:0]  command_thread,
	input  logic                  result_valid,
	input  logic                  result_ready,
	output logic                  advance,
	output logic                  s1_valid,
	output scalar_pkg::opcode_e   s1_op,
	output scalar_pkg::reg_idx_t  s1_dst
);

	logic accept;

	// Whole pipeline freezes while a result waits at the output
	assign advance       = !(result_valid && !result_ready);
	assign command_ready = advance;
	assign accept        = command_valid && command_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= accept;
		end
	end

	// Window base is thread * WIN_REGS, so the thread id forms the upper bits
	always_ff @(posedge clock) begin
		if (advance) begin
			s1_op  <= command_op;
			s1_dst <= {command_thread, command_dst};
		end
	end

endmodule

// File: verilog/operand_read.sv
// Operand read stage. Reads the register file with the indices from
// the index units, picks register data or the immediate per source
// and registers the command for the execute stage.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module operand_read (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  advance,
	input  logic                  s1_valid,
	input  scalar_pkg::opcode_e   s1_op,
	input  scalar_pkg::reg_idx_t  s1_dst,
	input  logic                  operand_is_imm [`NUM_SRC],
	input  scalar_pkg::reg_idx_t  operand_index [`NUM_SRC],
	input  scalar_pkg::data_t     operand_imm [`NUM_SRC],
	input  logic                  write_enable,
	input  scalar_pkg::reg_idx_t  write_index,
	input  scalar_pkg::data_t     write_data,
	output logic                  s2_valid,
	output scalar_pkg::opcode_e   s2_op,
	output scalar_pkg::reg_idx_t  s2_dst,
	output scalar_pkg::data_t     s2_src_data [`NUM_SRC]
);

	scalar_pkg::data_t rf_data [`NUM_SRC];
	scalar_pkg::data_t src_data [`NUM_SRC];

	reg_file u_reg_file (
		.clock        (clock),
		.reset        (reset),
		.write_enable (write_enable),
		.write_index  (write_index),
		.write_data   (write_data),
		.read_index   (operand_index),
		.read_data    (rf_data)
	);

	// Register or constant per source
	always_comb begin
		for (int p = 0; p < `NUM_SRC; p++) begin
			src_data[p] = operand_is_imm[p] ? operand_imm[p] : rf_data[p];
		end
	end

	////////////////////////////////////////////////////
	// Stage two register
	////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			s2_valid <= 1'b0;
		end else if (advance) begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			s2_op       <= s1_op;
			s2_dst      <= s1_dst;
			s2_src_data <= src_data;
		end
	end

endmodule

// File: verilog/reg_file.sv
// Shared scalar register file holding every thread window.
// Three combinational read ports and one synchronous write port,
// a write is visible to reads from the next cycle on.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module reg_file (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  write_enable,
	input  scalar_pkg::reg_idx_t  write_index,
	input  scalar_pkg::data_t     write_data,
	input  scalar_pkg::reg_idx_t  read_index [`NUM_SRC],
	output scalar_pkg::data_t     read_data [`NUM_SRC]
);

	scalar_pkg::data_t words [`NUM_REGS];

	// Every register reads zero after reset
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				words[i] <= '0;
			end
		end else if (write_enable) begin
			words[write_index] <= write_data;
		end
	end

	always_comb begin
		for (int p = 0; p < `NUM_SRC; p++) begin
			read_data[p] = words[read_index[p]];
		end
	end

endmodule

// File: verilog/scalar_alu.sv
// Execute stage. Computes the scalar operation, captures it in the
// result register on advance and drives the register-file write on
// the same edge. The result register is the output of the unit.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module scalar_alu (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  advance,
	input  logic                  s2_valid,
	input  scalar_pkg::opcode_e   s2_op,
	input  scalar_pkg::reg_idx_t  s2_dst,
	input  scalar_pkg::data_t     s2_src_data [`NUM_SRC],
	output logic                  result_valid,
	input  logic                  result_ready,
	output scalar_pkg::reg_idx_t  result_index,
	output scalar_pkg::data_t     result_data,
	output logic                  write_enable,
	output scalar_pkg::reg_idx_t  write_index,
	output scalar_pkg::data_t     write_data
);

	scalar_pkg::data_t exec_data;

	always_comb begin
		unique case (s2_op)
			scalar_pkg::OP_ADD: exec_data = s2_src_data[0] + s2_src_data[1] + s2_src_data[2];
			scalar_pkg::OP_SUB: exec_data = s2_src_data[0] - s2_src_data[1];
			scalar_pkg::OP_AND: exec_data = s2_src_data[0] & s2_src_data[1];
			// Product kept to the low word
			scalar_pkg::OP_MAC: exec_data = s2_src_data[0] * s2_src_data[1] + s2_src_data[2];
		endcase
	end

	// Write back together with the result capture
	assign write_enable = s2_valid && advance;
	assign write_index  = s2_dst;
	assign write_data   = exec_data;

	////////////////////////////////////////////////////
	// Result register
	////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else if (advance) begin
			result_valid <= s2_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			result_index <= s2_dst;
			result_data  <= exec_data;
		end
	end

	// A result waiting for the consumer must not move
	a_hold_stall: assert property (@(posedge clock) disable iff (reset)
		(result_valid && !result_ready) |=> ($stable(result_index) && $stable(result_data)))
		else $error("result changed while stalled");

endmodule

// File: verilog/scalar_defs.svh
// Size definitions for the scalar back-end pipeline.
// Include wherever a data, immediate, register or thread width is needed.

`ifndef SCALAR_DEFS_SVH
`define SCALAR_DEFS_SVH

// Data path
`define DATA_W      32
`define IMM_W       12

// Register windows, one per thread
`define WIN_REGS    8
`define WIN_IDX_W   3
`define NUM_THREADS 4
`define THREAD_W    2

// Physical register file (windows times registers per window)
`define NUM_REGS    32
`define REG_IDX_W   5

// Source operands per command
`define NUM_SRC     3

`endif

// File: verilog/scalar_pkg.sv
// Shared types of the scalar back-end pipeline.
// Modules refer to them by scoped name, e.g. scalar_pkg::data_t.

`include "scalar_defs.svh"

package scalar_pkg;

	// Scalar operations
	typedef enum logic [1:0] {
		OP_ADD = 2'd0,	// src1 + src2 + src3
		OP_SUB = 2'd1,	// src1 - src2
		OP_AND = 2'd2,	// src1 & src2
		OP_MAC = 2'd3	// low word of src1 * src2, plus src3
	} opcode_e;

	////////////////////////////////////////////////////
	// Source field, read as register index or constant
	////////////////////////////////////////////////////

	typedef struct packed {
		logic [`IMM_W-`WIN_IDX_W-1:0] pad;
		logic [`WIN_IDX_W-1:0]        idx;
	} src_reg_t;

	typedef union packed {
		src_reg_t                  regs;
		logic signed [`IMM_W-1:0]  imm;
	} src_field_u;

	// is_imm picks the view of the field
	typedef struct packed {
		logic       is_imm;
		src_field_u field;
	} src_operand_t;

	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	typedef logic [`DATA_W-1:0] data_t;

endpackage

// File: verilog/scalar_unit_top.sv
// Top of the scalar back-end pipeline.
// Command in on a valid/ready handshake, result out three cycles later
// and written back to the shared register file.

`timescale 1ns/1ps

`include "scalar_defs.svh"

module scalar_unit_top (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      command_valid,
	output logic                      command_ready,
	input  scalar_pkg::opcode_e       command_op,
	input  logic [`WIN_IDX_W-1:0]     command_dst,
	input  scalar_pkg::src_operand_t  command_src [`NUM_SRC],
	input  logic [`THREAD_W-1:0]      command_thread,
	output logic                      result_valid,
	input  logic                      result_ready,
	output scalar_pkg::reg_idx_t      result_index,
	output scalar_pkg::data_t         result_data
);

	logic                  advance;
	logic                  s1_valid;
	scalar_pkg::opcode_e   s1_op;
	scalar_pkg::reg_idx_t  s1_dst;
	logic                  operand_is_imm [`NUM_SRC];
	scalar_pkg::reg_idx_t  operand_index [`NUM_SRC];
	scalar_pkg::data_t     operand_imm [`NUM_SRC];
	logic                  s2_valid;
	scalar_pkg::opcode_e   s2_op;
	scalar_pkg::reg_idx_t  s2_dst;
	scalar_pkg::data_t     s2_src_data [`NUM_SRC];
	logic                  write_enable;
	scalar_pkg::reg_idx_t  write_index;
	scalar_pkg::data_t     write_data;

	issue_stage u_issue_stage (
		.clock          (clock),
		.reset          (reset),
		.command_valid  (command_valid),
		.command_ready  (command_ready),
		.command_op     (command_op),
		.command_dst    (command_dst),
		.command_thread (command_thread),
		.result_valid   (result_valid),
		.result_ready   (result_ready),
		.advance        (advance),
		.s1_valid       (s1_valid),
		.s1_op          (s1_op),
		.s1_dst         (s1_dst)
	);

	// One index unit per source operand
	for (genvar i = 0; i < `NUM_SRC; i++) begin : g_index
		index_unit u_index_unit (
			.clock          (clock),
			.reset          (reset),
			.advance        (advance),
			.src            (command_src[i]),
			.thread         (command_thread),
			.operand_is_imm (operand_is_imm[i]),
			.operand_index  (operand_index[i]),
			.operand_imm    (operand_imm[i])
		);
	end

	operand_read u_operand_read (
		.clock          (clock),
		.reset          (reset),
		.advance        (advance),
		.s1_valid       (s1_valid),
		.s1_op          (s1_op),
		.s1_dst         (s1_dst),
		.operand_is_imm (operand_is_imm),
		.operand_index  (operand_index),
		.operand_imm    (operand_imm),
		.write_enable   (write_enable),
		.write_index    (write_index),
		.write_data     (write_data),
		.s2_valid       (s2_valid),
		.s2_op          (s2_op),
		.s2_dst         (s2_dst),
		.s2_src_data    (s2_src_data)
	);

	scalar_alu u_scalar_alu (
		.clock        (clock),
		.reset        (reset),
		.advance      (advance),
		.s2_valid     (s2_valid),
		.s2_op        (s2_op),
		.s2_dst       (s2_dst),
		.s2_src_data  (s2_src_data),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.result_index (result_index),
		.result_data  (result_data),
		.write_enable (write_enable),
		.write_index  (write_index),
		.write_data   (write_data)
	);

endmodule
